// File: rtl/ooo_pkg.sv
package ooo_pkg;

	// Machine width and storage sizes
	localparam int lane_count = 2;   // Instructions renamed and retired per cycle
	localparam int arch_regs  = 32;
	localparam int phys_regs  = 64;
	localparam int rob_rows   = 16;

	// Index and tag widths follow from the sizes above
	typedef logic [$clog2(arch_regs)-1:0] arch_idx_t;
	typedef logic [$clog2(phys_regs)-1:0] phys_tag_t;
	typedef logic [$clog2(rob_rows)-1:0]  rob_ptr_t;

	// One extra bit so a full buffer (16) is representable
	typedef logic [$clog2(rob_rows):0]    rob_count_t;

	// Reorder-buffer row
	// busy  row holds a live instruction
	// ready its destination tag has been broadcast on the CDB
	// halt  retiring this row stops the machine
	typedef struct packed {
		logic      busy;
		logic      ready;
		logic      halt;
		arch_idx_t arch_dest;
		phys_tag_t t_new;   // Tag taken from the free list
		phys_tag_t t_old;   // Previous mapping freed at retire
	} rob_row_t;

endpackage

// File: rtl/dispatch_if.sv
`timescale 1ns/1ps

interface dispatch_if import ooo_pkg::*; ();

	// One entry per lane registered in the rename stage
	logic      [lane_count-1:0] valid;
	arch_idx_t [lane_count-1:0] arch_dest;
	phys_tag_t [lane_count-1:0] t_new;
	phys_tag_t [lane_count-1:0] t_old;
	logic      [lane_count-1:0] halt;

	// Rename only sends what the buffer has room for
	modport rename (
		output valid, arch_dest, t_new, t_old, halt
	);

	modport rob (
		input valid, arch_dest, t_new, t_old, halt
	);

endinterface

// File: rtl/rename_stage.sv
`timescale 1ns/1ps

module rename_stage import ooo_pkg::*; (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic       [lane_count-1:0] in_valid,
	input  arch_idx_t  [lane_count-1:0] in_arch_dest,
	input  logic       [lane_count-1:0] in_halt,
	input  rob_count_t                  free_rows,
	input  logic       [lane_count-1:0] free_valid,
	input  phys_tag_t  [lane_count-1:0] free_tag,
	input  phys_tag_t  [arch_regs-1:0]  arch_map,
	input  logic                        flush,
	output logic       [lane_count-1:0] in_accept,
	dispatch_if.rename                  dsp
);

	phys_tag_t map_q [arch_regs];        // Speculative map table
	logic [phys_regs-1:0] free_q;        // One bit per physical tag
	logic [phys_regs-1:0] free_d;
	logic [phys_regs-1:0] arch_free;     // Free set implied by arch_map

	phys_tag_t [lane_count-1:0] pick_tag;
	logic      [lane_count-1:0] pick_ok;
	phys_tag_t [lane_count-1:0] lane_tag;
	phys_tag_t [lane_count-1:0] lane_old;
	rob_count_t pend;
	rob_count_t room;
	logic [lane_count-1:0] alloc_clash;

	// Lowest free tags. A downward scan shifts earlier finds into the higher slot
	always_comb begin
		pick_ok = '0;
		pick_tag = '0;
		for (int t = phys_regs - 1; t >= 0; t--) begin
			if (free_q[t]) begin
				pick_tag[1] = pick_tag[0];
				pick_ok[1] = pick_ok[0];
				pick_tag[0] = phys_tag_t'(t);
				pick_ok[0] = 1'b1;
			end
		end
	end

	// Lanes sitting on dsp are not yet counted by the buffer
	always_comb begin
		pend = '0;
		for (int l = 0; l < lane_count; l++)
			pend = pend + rob_count_t'(dsp.valid[l]);
		room = free_rows - pend;
	end

	always_comb begin
		in_accept[0] = !flush && in_valid[0] && pick_ok[0] && (room != '0);
		if (in_accept[0])
			in_accept[1] = !flush && in_valid[1] && pick_ok[1] && (room >= rob_count_t'(2));
		else
			in_accept[1] = !flush && in_valid[1] && !in_valid[0] && pick_ok[0] && (room != '0);

		lane_tag[0] = pick_tag[0];
		lane_tag[1] = in_accept[0] ? pick_tag[1] : pick_tag[0];

		lane_old[0] = map_q[in_arch_dest[0]];
		if (in_accept[0] && in_arch_dest[1] == in_arch_dest[0])
			lane_old[1] = lane_tag[0];   // Same-group bypass
		else
			lane_old[1] = map_q[in_arch_dest[1]];
	end

	always_comb begin
		free_d = free_q;
		for (int l = 0; l < lane_count; l++)
			if (in_accept[l])
				free_d[lane_tag[l]] = 1'b0;
		for (int l = 0; l < lane_count; l++)
			if (free_valid[l])
				free_d[free_tag[l]] = 1'b1;   // Usable from the next edge
	end

	// Everything not architecturally mapped is free after a flush
	always_comb begin
		arch_free = '1;
		for (int r = 0; r < arch_regs; r++)
			arch_free[arch_map[r]] = 1'b0;
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int r = 0; r < arch_regs; r++)
				map_q[r] <= phys_tag_t'(r);   // Identity map
			for (int t = 0; t < phys_regs; t++)
				free_q[t] <= (t >= arch_regs);
			dsp.valid <= '0;
		end else if (flush) begin
			for (int r = 0; r < arch_regs; r++)
				map_q[r] <= arch_map[r];
			free_q <= arch_free;
			dsp.valid <= '0;
		end else begin
			free_q <= free_d;
			for (int l = 0; l < lane_count; l++)
				if (in_accept[l])
					map_q[in_arch_dest[l]] <= lane_tag[l];   // Lane 1 wins on a tie
			dsp.valid <= in_accept;
		end
	end

	always_ff @(posedge clock) begin
		dsp.arch_dest <= in_arch_dest;
		dsp.t_new <= lane_tag;
		dsp.t_old <= lane_old;
		dsp.halt <= in_halt;
	end

	always_comb begin
		alloc_clash = '0;
		for (int l = 0; l < lane_count; l++)
			for (int r = 0; r < arch_regs; r++)
				if (in_accept[l] && map_q[r] == lane_tag[l])
					alloc_clash[l] = 1'b1;
	end

	// Free list and map stay disjoint across retire returns
	a_alloc_unmapped: assert property (@(posedge clock) disable iff (!rst_n)
		alloc_clash == '0)
		else $error("rename handed out a tag that is still mapped");

endmodule

// File: rtl/tag_cam.sv
`timescale 1ns/1ps

module tag_cam import ooo_pkg::*; (
	input  logic      [lane_count-1:0] cdb_valid,
	input  phys_tag_t [lane_count-1:0] cdb_tag,
	input  phys_tag_t [rob_rows-1:0]   row_tags,
	output logic      [rob_rows-1:0]   hits
);

	// Every row against every broadcast
	// Row busy gating is left to the buffer
	always_comb begin
		hits = '0;
		for (int r = 0; r < rob_rows; r++) begin
			for (int l = 0; l < lane_count; l++) begin
				if (cdb_valid[l] && cdb_tag[l] == row_tags[r])
					hits[r] = 1'b1;
			end
		end
	end

endmodule

// File: rtl/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer import ooo_pkg::*; (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic       [lane_count-1:0] cdb_valid,
	input  phys_tag_t  [lane_count-1:0] cdb_tag,
	input  logic                        flush,
	dispatch_if.rob                     dsp,
	output logic       [lane_count-1:0] retire_valid,
	output rob_row_t   [lane_count-1:0] retire_row,
	output rob_count_t                  free_rows,
	output logic                        halted
);

	rob_row_t rows_q [rob_rows];
	rob_row_t rows_d [rob_rows];

	rob_ptr_t   head_q;
	rob_ptr_t   tail_q;
	rob_count_t count_q;
	logic       halted_q;

	phys_tag_t [rob_rows-1:0] row_tags;
	logic      [rob_rows-1:0] hits;

	rob_ptr_t [lane_count-1:0] ret_ptr;
	rob_ptr_t [lane_count-1:0] wr_ptr;
	rob_count_t ret_num;
	rob_count_t wr_num;
	rob_count_t busy_count;
	logic       go;
	logic       halt_seen;

	always_comb begin
		for (int r = 0; r < rob_rows; r++)
			row_tags[r] = rows_q[r].t_new;
	end

	tag_cam u_cam (
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.row_tags  (row_tags),
		.hits      (hits)
	);

	// In-order pick from the head up to a halt
	always_comb begin
		go = !flush && !halted_q;
		halt_seen = 1'b0;
		for (int l = 0; l < lane_count; l++) begin
			ret_ptr[l] = head_q + rob_ptr_t'(l);
			retire_row[l] = rows_q[ret_ptr[l]];
			retire_valid[l] = go && rows_q[ret_ptr[l]].busy && rows_q[ret_ptr[l]].ready;
			if (retire_valid[l] && rows_q[ret_ptr[l]].halt)
				halt_seen = 1'b1;
			go = retire_valid[l] && !rows_q[ret_ptr[l]].halt;
		end
	end

	always_comb begin
		rows_d = rows_q;

		// CDB wakeup reaches live rows only
		for (int r = 0; r < rob_rows; r++)
			rows_d[r].ready = rows_q[r].ready | (hits[r] & rows_q[r].busy);

		ret_num = '0;
		for (int l = 0; l < lane_count; l++) begin
			if (retire_valid[l]) begin
				rows_d[ret_ptr[l]].busy = 1'b0;
				ret_num = ret_num + 1'b1;
			end
		end

		// Valid lanes are packed at the tail even if lane 0 was empty
		wr_num = '0;
		for (int l = 0; l < lane_count; l++) begin
			wr_ptr[l] = tail_q + rob_ptr_t'(wr_num);
			if (dsp.valid[l]) begin
				rows_d[wr_ptr[l]].busy = 1'b1;
				rows_d[wr_ptr[l]].ready = 1'b0;
				rows_d[wr_ptr[l]].halt = dsp.halt[l];
				rows_d[wr_ptr[l]].arch_dest = dsp.arch_dest[l];
				rows_d[wr_ptr[l]].t_new = dsp.t_new[l];
				rows_d[wr_ptr[l]].t_old = dsp.t_old[l];
				wr_num = wr_num + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n || flush) begin
			for (int r = 0; r < rob_rows; r++)
				rows_q[r].busy <= 1'b0;
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else begin
			rows_q <= rows_d;
			head_q <= head_q + rob_ptr_t'(ret_num);
			tail_q <= tail_q + rob_ptr_t'(wr_num);
			count_q <= count_q + wr_num - ret_num;
		end
	end

	// Sticky until reset even across a flush
	always_ff @(posedge clock) begin
		if (!rst_n)
			halted_q <= 1'b0;
		else if (halt_seen)
			halted_q <= 1'b1;
	end

	assign halted = halted_q;
	assign free_rows = rob_count_t'(rob_rows) - count_q;

	always_comb begin
		busy_count = '0;
		for (int r = 0; r < rob_rows; r++)
			busy_count = busy_count + rob_count_t'(rows_q[r].busy);
	end

	// Rename must have left room for every lane it sent
	a_no_overflow: assert property (@(posedge clock) disable iff (!rst_n)
		wr_num <= free_rows)
		else $error("reorder buffer written while full");

	a_count_busy: assert property (@(posedge clock) disable iff (!rst_n)
		count_q == busy_count)
		else $error("reorder buffer count %0d, busy rows %0d", count_q, busy_count);

endmodule

// File: rtl/retire_stage.sv
`timescale 1ns/1ps

module retire_stage import ooo_pkg::*; (
	input  logic                       clock,
	input  logic                       rst_n,
	input  logic      [lane_count-1:0] retire_valid,
	input  rob_row_t  [lane_count-1:0] retire_row,
	output logic      [lane_count-1:0] out_valid,
	output arch_idx_t [lane_count-1:0] out_arch_dest,
	output phys_tag_t [lane_count-1:0] out_t_new,
	output phys_tag_t [lane_count-1:0] out_t_old,
	output logic                       out_halt,
	output logic      [lane_count-1:0] free_valid,
	output phys_tag_t [lane_count-1:0] free_tag,
	output phys_tag_t [arch_regs-1:0]  arch_map
);

	logic halt_hit;

	always_comb begin
		halt_hit = 1'b0;
		for (int l = 0; l < lane_count; l++)
			if (retire_valid[l] && retire_row[l].halt)
				halt_hit = 1'b1;
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			out_valid <= '0;
			out_halt <= 1'b0;
			for (int r = 0; r < arch_regs; r++)
				arch_map[r] <= phys_tag_t'(r);
		end else begin
			out_valid <= retire_valid;
			out_halt <= halt_hit;
			// Later lane is younger so it overwrites
			for (int l = 0; l < lane_count; l++)
				if (retire_valid[l])
					arch_map[retire_row[l].arch_dest] <= retire_row[l].t_new;
		end
	end

	always_ff @(posedge clock) begin
		for (int l = 0; l < lane_count; l++) begin
			out_arch_dest[l] <= retire_row[l].arch_dest;
			out_t_new[l] <= retire_row[l].t_new;
			out_t_old[l] <= retire_row[l].t_old;
		end
	end

	// Old mapping goes back to the free list as the row leaves
	assign free_valid = out_valid;
	assign free_tag = out_t_old;

endmodule

// File: rtl/ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top import ooo_pkg::*; (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic       [lane_count-1:0] in_valid,
	input  arch_idx_t  [lane_count-1:0] in_arch_dest,
	input  logic       [lane_count-1:0] in_halt,
	input  logic       [lane_count-1:0] cdb_valid,
	input  phys_tag_t  [lane_count-1:0] cdb_tag,
	input  logic                        flush,
	output logic       [lane_count-1:0] in_accept,
	output logic       [lane_count-1:0] out_valid,
	output arch_idx_t  [lane_count-1:0] out_arch_dest,
	output phys_tag_t  [lane_count-1:0] out_t_new,
	output phys_tag_t  [lane_count-1:0] out_t_old,
	output logic                        out_halt,
	output logic                        halted,
	output rob_count_t                  free_rows
);

	dispatch_if dsp ();

	logic      [lane_count-1:0] retire_valid;
	rob_row_t  [lane_count-1:0] retire_row;
	logic      [lane_count-1:0] free_valid;
	phys_tag_t [lane_count-1:0] free_tag;
	phys_tag_t [arch_regs-1:0]  arch_map;

	rename_stage u_rename (
		.clock        (clock),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_arch_dest (in_arch_dest),
		.in_halt      (in_halt),
		.free_rows    (free_rows),
		.free_valid   (free_valid),
		.free_tag     (free_tag),
		.arch_map     (arch_map),
		.flush        (flush),
		.in_accept    (in_accept),
		.dsp          (dsp.rename)
	);

	reorder_buffer u_rob (
		.clock        (clock),
		.rst_n        (rst_n),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.flush        (flush),
		.dsp          (dsp.rob),
		.retire_valid (retire_valid),
		.retire_row   (retire_row),
		.free_rows    (free_rows),
		.halted       (halted)
	);

	retire_stage u_retire (
		.clock         (clock),
		.rst_n         (rst_n),
		.retire_valid  (retire_valid),
		.retire_row    (retire_row),
		.out_valid     (out_valid),
		.out_arch_dest (out_arch_dest),
		.out_t_new     (out_t_new),
		.out_t_old     (out_t_old),
		.out_halt      (out_halt),
		.free_valid    (free_valid),
		.free_tag      (free_tag),
		.arch_map      (arch_map)
	);

endmodule

// File: test/ooo_tb.sv
`timescale 1ns/1ps

module ooo_tb import ooo_pkg::*; ();

	localparam int reset_cycles = 16;
	localparam int run_a = 1000;       // Traffic before the flush
	localparam int run_b = 700;        // Traffic after it
	localparam int halt_wait = 284;    // Halt draining plus the quiet tail
	localparam int quiet_cycles = 40;
	localparam int timeout_cycles = 2 * (reset_cycles + run_a + run_b + halt_wait);

	logic                       clock = 1'b0;
	logic                       rst_n;
	logic      [lane_count-1:0] in_valid;
	arch_idx_t [lane_count-1:0] in_arch_dest;
	logic      [lane_count-1:0] in_halt;
	logic      [lane_count-1:0] cdb_valid;
	phys_tag_t [lane_count-1:0] cdb_tag;
	logic                       flush;
	logic      [lane_count-1:0] in_accept;
	logic      [lane_count-1:0] out_valid;
	arch_idx_t [lane_count-1:0] out_arch_dest;
	phys_tag_t [lane_count-1:0] out_t_new;
	phys_tag_t [lane_count-1:0] out_t_old;
	logic                       out_halt;
	logic                       halted;
	rob_count_t                 free_rows;

	ooo_core_top dut (.*);

	always #10 clock = ~clock;

	logic [31:0] lfsr;
	int cycles;
	int mismatches;
	int faults;

	// Instruction words are {halt, arch_dest}
	logic [5:0] src_q[$];              // Offered but not yet accepted
	logic [5:0] prog_q[$];             // Accepted and waiting to retire
	logic [5:0] lane_word [lane_count];
	phys_tag_t wake_q[$];              // Buffered rows not yet broadcast
	phys_tag_t stage_q[$];             // Seen on dispatch and written next edge
	logic [phys_regs-1:0] live;        // New tags of in-flight instructions
	phys_tag_t exp_map [arch_regs];    // Last retired tag per register

	// Expected values only change on falling edges
	arch_idx_t [lane_count-1:0] exp_dest;
	phys_tag_t [lane_count-1:0] exp_old;
	logic exp_halt;
	int exp_count;                     // Rows the buffer should hold
	int acc_prev;
	int in_flight;
	logic [lane_count-1:0] acc_now;
	logic seen_accept;
	logic phantom;
	logic dup_tag;
	logic stray_tag;
	logic halt_flag;
	logic halt_pending;
	logic flush_prev;

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [5:0] new_word();
		logic [31:0] r;
		logic [5:0] w;
		r = rand_bits(5);
		w = {halt_pending, r[4:0]};
		halt_pending = 1'b0;
		return w;
	endfunction

	task automatic put_lane(input int l, input logic [5:0] w);
		in_valid[l] = 1'b1;
		in_arch_dest[l] = w[4:0];
		in_halt[l] = w[5];
		lane_word[l] = w;
	endtask

	// Turns outputs of the last rising edge into expected values
	task automatic observe();
		logic [5:0] w;
		phys_tag_t tag;
		int retired;
		retired = 0;
		exp_halt = 1'b0;
		phantom = 1'b0;
		dup_tag = 1'b0;
		stray_tag = 1'b0;
		for (int l = 0; l < lane_count; l++) begin
			if (out_valid[l]) begin
				retired++;
				if (prog_q.size() == 0) begin
					phantom = 1'b1;
				end else begin
					w = prog_q.pop_front();
					exp_dest[l] = w[4:0];
					exp_halt = exp_halt | w[5];
					exp_old[l] = exp_map[w[4:0]];   // Lane 1 sees lane 0's update
					if (!live[out_t_new[l]])
						stray_tag = 1'b1;
					exp_map[w[4:0]] = out_t_new[l];
					live[out_t_new[l]] = 1'b0;
				end
			end
		end
		if (out_halt)
			halt_flag = 1'b1;
		if (flush_prev) begin
			exp_count = 0;   // Buffer and dispatch lanes emptied
			acc_prev = 0;
		end else begin
			exp_count = exp_count + acc_prev - retired;
			acc_prev = $countones(acc_now);
		end
		in_flight = exp_count + acc_prev;
		if (acc_now != '0)
			seen_accept = 1'b1;
		while (stage_q.size() > 0)
			wake_q.push_back(stage_q.pop_front());
		// Tags now on the dispatch interface
		for (int l = 0; l < lane_count; l++) begin
			if (dut.dsp.valid[l]) begin
				tag = dut.dsp.t_new[l];
				if (live[tag])
					dup_tag = 1'b1;
				live[tag] = 1'b1;
				stage_q.push_back(tag);
			end
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] pattern;
		int n;
		int idx;
		while (src_q.size() < lane_count)
			src_q.push_back(new_word());
		in_valid = '0;
		in_arch_dest = '0;
		in_halt = '0;
		pattern = rand_bits(2);
		case (pattern[1:0])
			2'd1: put_lane(0, src_q[0]);
			2'd2: put_lane(1, src_q[0]);
			2'd3: begin
				put_lane(0, src_q[0]);
				put_lane(1, src_q[1]);
			end
			default: ;
		endcase
		cdb_valid = '0;
		cdb_tag = '0;
		n = 0;
		if (cycles % 64 < 48)   // Quiet windows let the buffer fill up
			n = 1 + int'(rand_bits(1));
		for (int l = 0; l < n; l++) begin
			if (wake_q.size() > 0) begin
				idx = int'(rand_bits(5) % wake_q.size());
				cdb_valid[l] = 1'b1;
				cdb_tag[l] = wake_q[idx];
				wake_q.delete(idx);
			end
		end
	endtask

	task automatic record_accepts();
		acc_now = in_accept;
		for (int l = 0; l < lane_count; l++) begin
			if (in_accept[l]) begin
				prog_q.push_back(lane_word[l]);
				void'(src_q.pop_front());
			end
		end
	endtask

	// One cycle from falling edge to falling edge
	task automatic run_cycle(input logic do_flush);
		observe();
		if (do_flush) begin
			flush = 1'b1;
			in_valid = '0;
			cdb_valid = '0;
			prog_q.delete();   // Nothing older may retire
			wake_q.delete();
			stage_q.delete();
			live = '0;
		end else begin
			flush = 1'b0;
			drive_inputs();
		end
		flush_prev = do_flush;
		@(posedge clock);
		record_accepts();
		@(negedge clock);
	endtask

	initial begin
		lfsr = 32'hcf4a31d8;
		rst_n = 1'b0;
		flush = 1'b0;
		in_valid = '0;
		in_arch_dest = '0;
		in_halt = '0;
		cdb_valid = '0;
		cdb_tag = '0;
		cycles = 0;
		mismatches = 0;
		faults = 0;
		live = '0;
		exp_dest = '0;
		exp_old = '0;
		exp_halt = 1'b0;
		exp_count = 0;
		acc_prev = 0;
		in_flight = 0;
		acc_now = '0;
		seen_accept = 1'b0;
		phantom = 1'b0;
		dup_tag = 1'b0;
		stray_tag = 1'b0;
		halt_flag = 1'b0;
		halt_pending = 1'b0;
		flush_prev = 1'b0;
		for (int r = 0; r < arch_regs; r++)
			exp_map[r] = phys_tag_t'(r);   // Identity after reset
		repeat (reset_cycles) @(negedge clock);
		rst_n = 1'b1;
		repeat (run_a) run_cycle(1'b0);
		run_cycle(1'b1);
		repeat (run_b) run_cycle(1'b0);
		halt_pending = 1'b1;
		while (!halt_flag)
			run_cycle(1'b0);
		repeat (quiet_cycles) run_cycle(1'b0);
		$display("errors: %0d mismatches, %0d other failures", mismatches, faults);
		if (mismatches == 0 && faults == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("errors: %0d mismatches, %0d other failures", mismatches, faults);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	a_reset_idle: assert property (@(posedge clock) disable iff (!rst_n)
		!seen_accept |-> (out_valid == '0 && !halted && int'(free_rows) == rob_rows))
		else begin
			mismatches++;
			$display("MISMATCH reset_idle expected valid 0 halted 0 rows %0d actual %0d %0d %0d",
				rob_rows, $sampled(out_valid), $sampled(halted), $sampled(free_rows));
		end

	for (genvar l = 0; l < lane_count; l++) begin : g_lane
		a_dest: assert property (@(posedge clock) disable iff (!rst_n)
			out_valid[l] && !phantom |-> out_arch_dest[l] == exp_dest[l])
			else begin
				mismatches++;
				$display("MISMATCH retire_order lane %0d expected %0d actual %0d",
					l, exp_dest[l], $sampled(out_arch_dest[l]));
			end

		a_old: assert property (@(posedge clock) disable iff (!rst_n)
			out_valid[l] && !phantom |-> out_t_old[l] == exp_old[l])
			else begin
				mismatches++;
				$display("MISMATCH rename_old lane %0d expected %0d actual %0d",
					l, exp_old[l], $sampled(out_t_old[l]));
			end
	end

	a_lane_pair: assert property (@(posedge clock) disable iff (!rst_n)
		out_valid[1] |-> out_valid[0])
		else begin
			faults++;
			$display("lane 1 retired without lane 0");
		end

	a_phantom: assert property (@(posedge clock) disable iff (!rst_n) !phantom)
		else begin
			faults++;
			$display("an instruction retired that was never accepted or was flushed");
		end

	a_unique_tag: assert property (@(posedge clock) disable iff (!rst_n) !dup_tag)
		else begin
			faults++;
			$display("two in-flight instructions were given the same new tag");
		end

	a_known_tag: assert property (@(posedge clock) disable iff (!rst_n) !stray_tag)
		else begin
			faults++;
			$display("a retired instruction carried a new tag that was not in flight");
		end

	a_halt_out: assert property (@(posedge clock) disable iff (!rst_n)
		out_halt == exp_halt)
		else begin
			mismatches++;
			$display("MISMATCH halt_retire expected %0d actual %0d",
				exp_halt, $sampled(out_halt));
		end

	a_free_rows: assert property (@(posedge clock) disable iff (!rst_n)
		int'(free_rows) == rob_rows - exp_count)
		else begin
			mismatches++;
			$display("MISMATCH capacity expected %0d actual %0d",
				rob_rows - exp_count, $sampled(free_rows));
		end

	a_no_overfill: assert property (@(posedge clock) disable iff (!rst_n)
		in_flight + $countones(in_accept) <= rob_rows)
		else begin
			faults++;
			$display("accepted %0d lanes with %0d instructions already in flight",
				$countones($sampled(in_accept)), in_flight);
		end

	a_flush_empty: assert property (@(posedge clock) disable iff (!rst_n)
		$past(flush) |-> int'(free_rows) == rob_rows)
		else begin
			mismatches++;
			$display("MISMATCH flush_empty expected %0d actual %0d",
				rob_rows, $sampled(free_rows));
		end

	a_halt_sticky: assert property (@(posedge clock) disable iff (!rst_n)
		halt_flag |-> halted)
		else begin
			faults++;
			$display("halted dropped after a halt retired");
		end

	// The halt's own group is the last one out
	a_halt_quiet: assert property (@(posedge clock) disable iff (!rst_n)
		halt_flag && !out_halt |-> out_valid == '0)
		else begin
			faults++;
			$display("an instruction retired after the halt");
		end

endmodule

// File: tb.f
rtl/ooo_pkg.sv
rtl/dispatch_if.sv
rtl/rename_stage.sv
rtl/tag_cam.sv
rtl/reorder_buffer.sv
rtl/retire_stage.sv
rtl/ooo_core_top.sv
test/ooo_tb.sv

// File: Makefile
# Verilator build and run of the rename and retire testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= ooo_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
